// File: flist.f
rtl/sdCardPkg.sv
rtl/sdCrc7.sv
rtl/sdCmdReceiver.sv
rtl/sdCardState.sv
rtl/sdCmdDecoder.sv
rtl/sdRespTransmitter.sv
rtl/sdCardTop.sv
test/tbSdCard.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tbSdCard
FLIST     := flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: test/tbSdCard.sv
`timescale 1ns/1ps

module tbSdCard;
    import sdCardPkg::*;

    localparam int NUM_ROWS     = 16;
    localparam int QUIET_CYCLES = 12;
    // Falling edges from driving the last command bit to the first response bit
    localparam int FIRST_GAP    = 4;

    localparam int KIND_NONE = 0;
    localparam int KIND_R1   = 1;
    localparam int KIND_R2   = 2;
    localparam int KIND_R3   = 3;

    logic sd_clk;
    logic reset;
    logic cmdIn;
    logic cmdOut;
    logic cmdOutEn;
    logic cmdError;

    logic [5:0]  rowIdx     [NUM_ROWS];
    logic [31:0] rowArg     [NUM_ROWS];
    bit          rowRandArg [NUM_ROWS];
    bit          rowBadCrc  [NUM_ROWS];
    int          rowKind    [NUM_ROWS];
    logic [31:0] rowRespArg [NUM_ROWS];
    bit          rowExpErr  [NUM_ROWS];
    int          rowsLoaded;

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          errPulses;

    sdCardTop i_dut (
        .sd_clk   (sd_clk),
        .reset    (reset),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .cmdError (cmdError)
    );

    initial begin
        sd_clk = 1'b0;
        forever #4 sd_clk = ~sd_clk;
    end

    // ======================================================================
    // Host side helpers
    // ======================================================================
    function automatic logic [6:0] crc7Of(input logic [39:0] data);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = data[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randomWord();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return word;
    endfunction

    task automatic sendFrame(input logic [5:0] idx, input logic [31:0] arg, input bit badCrc);
        logic [39:0] hdr;
        logic [6:0]  crc;
        logic [47:0] frame;
        hdr = {2'b01, idx, arg};
        crc = crc7Of(hdr);
        if (badCrc) begin
            crc = crc ^ 7'h01;
        end
        frame = {hdr, crc, 1'b1};
        for (int i = 47; i >= 0; i--) begin
            @(negedge sd_clk);
            cmdIn = frame[i];
        end
    endtask

    // Records the card's drive on CMD until it releases the line or stays quiet
    task automatic watchResponse(output int nBits, output logic [R2_BITS-1:0] bits,
                                 output int firstGap, output bit errSeen);
        int gap;
        bit done;
        nBits    = 0;
        bits     = '0;
        firstGap = -1;
        errSeen  = 1'b0;
        gap      = 0;
        done     = 1'b0;
        while (!done) begin
            @(negedge sd_clk);
            gap++;
            if (cmdError) begin
                errSeen = 1'b1;
            end
            if (cmdOutEn) begin
                if (nBits == 0) begin
                    firstGap = gap;
                end
                bits = {bits[R2_BITS-2:0], cmdOut};
                nBits++;
                done = (nBits > R2_BITS);
            end else if (nBits != 0 || gap >= QUIET_CYCLES) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic checkValue(input string what, input logic [R2_BITS-1:0] got,
                              input logic [R2_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic addRow(input logic [5:0] idx, input logic [31:0] arg, input bit randArg,
                          input bit badCrc, input int kind, input logic [31:0] respArg,
                          input bit expErr);
        rowIdx[rowsLoaded]     = idx;
        rowArg[rowsLoaded]     = arg;
        rowRandArg[rowsLoaded] = randArg;
        rowBadCrc[rowsLoaded]  = badCrc;
        rowKind[rowsLoaded]    = kind;
        rowRespArg[rowsLoaded] = respArg;
        rowExpErr[rowsLoaded]  = expErr;
        rowsLoaded++;
    endtask

    // ======================================================================
    // Stimulus table and run
    // ======================================================================
    task automatic loadTable();
        // Index, argument, random arg, bad CRC, response kind, response arg, error
        addRow(6'd8, 32'h0, 1, 0, KIND_R1, 32'h0, 0);
        addRow(6'd8, 32'h0, 1, 0, KIND_R1, 32'h0, 0);
        addRow(6'd8, 32'h0, 1, 0, KIND_R1, 32'h0, 0);
        addRow(6'd3, 32'h0, 0, 0, KIND_R1, {CARD_RCA, 16'h0000}, 0);
        addRow(6'd7, {CARD_RCA, 16'h0000}, 0, 0, KIND_R1, CARD_STATUS_R1, 0);
        addRow(6'd7, 32'h1234_0000, 0, 0, KIND_NONE, 32'h0, 1);
        addRow(6'd8, 32'h0000_01AA, 0, 1, KIND_NONE, 32'h0, 1);
        addRow(6'd8, 32'h0000_01AA, 0, 0, KIND_R1, 32'h0000_01AA, 0);
        addRow(6'd55, {CARD_RCA, 16'h0000}, 0, 0, KIND_R1, CARD_STATUS_R1, 0);
        addRow(6'd41, 32'h40FF_8000, 0, 0, KIND_R3, 32'h0, 0);
        // Same index without the CMD55 prefix
        addRow(6'd41, 32'h40FF_8000, 0, 0, KIND_NONE, 32'h0, 1);
        addRow(6'd55, {CARD_RCA, 16'h0000}, 0, 0, KIND_R1, CARD_STATUS_R1, 0);
        addRow(6'd6, 32'h0000_0002, 0, 0, KIND_R1, CARD_STATUS_R1, 0);
        addRow(6'd2, 32'h0, 0, 0, KIND_R2, 32'h0, 0);
        addRow(6'd0, 32'h0, 0, 0, KIND_NONE, 32'h0, 0);
        // RCA is gone after CMD0
        addRow(6'd7, {CARD_RCA, 16'h0000}, 0, 0, KIND_NONE, 32'h0, 1);
    endtask

    always @(negedge sd_clk) begin
        if (reset) begin
            errPulses <= 0;
        end else if (cmdError) begin
            errPulses <= errPulses + 1;
        end
    end

    initial begin
        logic [R2_BITS-1:0] expBits;
        logic [R2_BITS-1:0] gotBits;
        logic [39:0]        hdr;
        logic [31:0]        arg;
        logic [31:0]        respArg;
        int                 expLen;
        int                 gotLen;
        int                 gap;
        int                 expErrTotal;
        bit                 gotErr;
        reset       = 1'b1;
        cmdIn       = 1'b1;
        lfsr        = 16'd31;
        errors      = 0;
        checks      = 0;
        rowsLoaded  = 0;
        expErrTotal = 0;
        loadTable();
        repeat (10) @(negedge sd_clk);
        reset = 1'b0;
        @(negedge sd_clk);
        checkValue("idle cmdOut", cmdOut, 1);
        checkValue("idle cmdOutEn", cmdOutEn, 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            arg     = rowArg[r];
            respArg = rowRespArg[r];
            if (rowRandArg[r]) begin
                arg     = randomWord();
                respArg = arg;
            end
            sendFrame(rowIdx[r], arg, rowBadCrc[r]);
            watchResponse(gotLen, gotBits, gap, gotErr);
            expLen = 48;
            case (rowKind[r])
                KIND_R1: begin
                    hdr     = {2'b00, rowIdx[r], respArg};
                    expBits = {hdr, crc7Of(hdr), 1'b1};
                end
                KIND_R3: expBits = {2'b00, 6'h3F, OCR_READY, 7'h7F, 1'b1};
                KIND_R2: begin
                    expBits = CARD_CID;
                    expLen  = R2_BITS;
                end
                default: begin
                    expBits = '0;
                    expLen  = 0;
                end
            endcase
            if (rowExpErr[r]) begin
                expErrTotal++;
            end
            if (rowExpErr[r] && !gotErr) begin
                errors++;
                $display("Row %0d: the card accepted a command it should reject", r);
            end else if (!rowExpErr[r] && gotErr) begin
                errors++;
                $display("Row %0d: the card rejected a valid command", r);
            end
            if (expLen != 0 && gotLen == 0) begin
                errors++;
                $display("Row %0d: the card sent no response", r);
            end else begin
                checkValue($sformatf("row %0d bit count", r), gotLen, expLen);
                if (expLen != 0) begin
                    checkValue($sformatf("row %0d response", r), gotBits, expBits);
                    checkValue($sformatf("row %0d first bit gap", r), gap, FIRST_GAP);
                end
            end
            @(negedge sd_clk);
        end
        checkValue("cmdError pulse total", errPulses, expErrTotal);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Each row needs well under 300 cycles even for a CID response
    initial begin
        repeat ((NUM_ROWS * 300) + 20) @(posedge sd_clk);
        $display("Timeout: the command sequence did not complete in time");
        $display("sim failed");
        $finish;
    end

endmodule

// File: rtl/sdCardTop.sv
`timescale 1ns/1ps

module sdCardTop (
    input  logic sd_clk,
    input  logic reset,
    input  logic cmdIn,
    output logic cmdOut,
    output logic cmdOutEn,
    output logic cmdError
);
    import sdCardPkg::*;

    logic                   frameValid;
    logic                   frameOk;
    logic [IDX_WIDTH-1:0]   frameIndex;
    logic [ARG_WIDTH-1:0]   frameArg;
    logic [15:0]            rca;
    logic                   appCmd;
    logic                   respStart;
    respKind_t              respKind;
    logic [HEADER_BITS-1:0] respHeader;
    logic                   setRca;
    logic                   clearRca;
    logic                   setApp;
    logic                   clearApp;
    logic                   respBusy;

    sdCmdReceiver i_receiver (
        .sd_clk     (sd_clk),
        .reset      (reset),
        .cmdIn      (cmdIn),
        .respBusy   (respBusy),
        .frameValid (frameValid),
        .frameOk    (frameOk),
        .frameIndex (frameIndex),
        .frameArg   (frameArg)
    );

    sdCardState i_state (
        .sd_clk   (sd_clk),
        .reset    (reset),
        .setRca   (setRca),
        .clearRca (clearRca),
        .setApp   (setApp),
        .clearApp (clearApp),
        .rca      (rca),
        .appCmd   (appCmd)
    );

    sdCmdDecoder i_decoder (
        .sd_clk     (sd_clk),
        .reset      (reset),
        .frameValid (frameValid),
        .frameOk    (frameOk),
        .frameIndex (frameIndex),
        .frameArg   (frameArg),
        .rca        (rca),
        .appCmd     (appCmd),
        .respStart  (respStart),
        .respKind   (respKind),
        .respHeader (respHeader),
        .setRca     (setRca),
        .clearRca   (clearRca),
        .setApp     (setApp),
        .clearApp   (clearApp),
        .cmdError   (cmdError)
    );

    sdRespTransmitter i_transmitter (
        .sd_clk     (sd_clk),
        .reset      (reset),
        .respStart  (respStart),
        .respKind   (respKind),
        .respHeader (respHeader),
        .cmdOut     (cmdOut),
        .cmdOutEn   (cmdOutEn),
        .respBusy   (respBusy)
    );

endmodule

// File: rtl/sdRespTransmitter.sv
`timescale 1ns/1ps

module sdRespTransmitter (
    input  logic                              sd_clk,
    input  logic                              reset,
    input  logic                              respStart,
    input  sdCardPkg::respKind_t              respKind,
    input  logic [sdCardPkg::HEADER_BITS-1:0] respHeader,
    output logic                              cmdOut,
    output logic                              cmdOutEn,
    output logic                              respBusy
);
    import sdCardPkg::*;

    localparam int GAP_W = $clog2(RESP_GAP + 1);

    logic                  waiting;
    logic [GAP_W-1:0]      gapCnt;
    logic [7:0]            bitCount;
    logic [7:0]            lastCount;
    logic [R2_BITS-1:0]    txBits;
    respKind_t             kindReg;
    logic                  startShift;
    logic                  loadBit;
    logic                  useCrc;
    logic                  outBit;
    logic [CRC7_WIDTH-1:0] crc;

    assign startShift = waiting && (gapCnt == GAP_W'(1));
    assign lastCount  = (kindReg == RESP_R2) ? 8'(R2_BITS) : 8'(CMD_FRAME_BITS);
    assign loadBit    = startShift || (cmdOutEn && (bitCount != lastCount));
    // R1 swaps in the computed CRC right after the header
    assign useCrc     = (kindReg == RESP_R1) && (bitCount == 8'(HEADER_BITS));
    assign outBit     = useCrc ? crc[CRC7_WIDTH-1] : txBits[R2_BITS-1];
    assign respBusy   = waiting || cmdOutEn;

    sdCrc7 i_crc (
        .sd_clk  (sd_clk),
        .reset   (reset),
        .clear   (respStart),
        .enable  (loadBit && (bitCount < 8'(HEADER_BITS))),
        .dataBit (txBits[R2_BITS-1]),
        .crc     (crc)
    );

    // ======================================================================
    // Gap counter and bit sequencing
    // ======================================================================
    always_ff @(posedge sd_clk) begin
        if (reset) begin
            waiting  <= 1'b0;
            gapCnt   <= '0;
            bitCount <= '0;
            cmdOutEn <= 1'b0;
            cmdOut   <= 1'b1;
        end else begin
            if (respStart) begin
                waiting  <= 1'b1;
                gapCnt   <= GAP_W'(RESP_GAP - 1);
                bitCount <= '0;
            end else if (startShift) begin
                waiting <= 1'b0;
            end else if (waiting) begin
                gapCnt <= gapCnt - 1'b1;
            end
            if (loadBit) begin
                cmdOut   <= outBit;
                cmdOutEn <= 1'b1;
                bitCount <= bitCount + 8'd1;
            end else if (cmdOutEn) begin
                // Release the line, it idles high
                cmdOutEn <= 1'b0;
                cmdOut   <= 1'b1;
            end
        end
    end

    always_ff @(posedge sd_clk) begin
        if (respStart) begin
            kindReg <= respKind;
            if (respKind == RESP_R2) begin
                txBits <= CARD_CID;
            end else begin
                txBits <= {respHeader, {CRC7_WIDTH{1'b1}}, 1'b1,
                           {(R2_BITS - CMD_FRAME_BITS){1'b0}}};
            end
        end else if (loadBit) begin
            if (useCrc) begin
                txBits <= {crc[CRC7_WIDTH-2:0], 1'b1, {(R2_BITS - CRC7_WIDTH){1'b0}}};
            end else begin
                txBits <= txBits << 1;
            end
        end
    end

    // Receiver stays blocked while busy, so no command can be decoded now
    assert property (@(posedge sd_clk) disable iff (reset) respStart |-> !respBusy);

endmodule

// File: rtl/sdCmdDecoder.sv
`timescale 1ns/1ps

module sdCmdDecoder (
    input  logic                             sd_clk,
    input  logic                             reset,
    input  logic                             frameValid,
    input  logic                             frameOk,
    input  logic [sdCardPkg::IDX_WIDTH-1:0]  frameIndex,
    input  logic [sdCardPkg::ARG_WIDTH-1:0]  frameArg,
    input  logic [15:0]                      rca,
    input  logic                             appCmd,
    output logic                             respStart,
    output sdCardPkg::respKind_t             respKind,
    output logic [sdCardPkg::HEADER_BITS-1:0] respHeader,
    output logic                             setRca,
    output logic                             clearRca,
    output logic                             setApp,
    output logic                             clearApp,
    output logic                             cmdError
);
    import sdCardPkg::*;

    cmdCode_t             code;
    logic                 rcaMatch;
    logic                 accept;
    logic                 respond;
    logic                 rcaSet;
    logic                 rcaClear;
    logic                 appSet;
    respKind_t            kindNext;
    logic [IDX_WIDTH-1:0] idxNext;
    logic [ARG_WIDTH-1:0] argNext;

    assign rcaMatch = (frameArg[31:16] == rca);

    // ======================================================================
    // Command rules
    // ======================================================================
    always_comb begin
        code     = cmdCode_t'({appCmd, frameIndex});
        accept   = 1'b1;
        respond  = 1'b1;
        rcaSet   = 1'b0;
        rcaClear = 1'b0;
        appSet   = 1'b0;
        kindNext = RESP_R1;
        argNext  = CARD_STATUS_R1;
        case (code)
            CMD0: begin
                respond  = 1'b0;
                rcaClear = 1'b1;
            end
            CMD2:  kindNext = RESP_R2;
            CMD3: begin
                argNext = {CARD_RCA, 16'h0000};
                rcaSet  = 1'b1;
            end
            CMD7:  accept = rcaMatch;
            CMD8:  argNext = frameArg;
            CMD55: begin
                accept = rcaMatch;
                appSet = 1'b1;
            end
            ACMD6: kindNext = RESP_R1;
            ACMD41: begin
                kindNext = RESP_R3;
                argNext  = OCR_READY;
            end
            default: accept = 1'b0;
        endcase
        if (!frameOk) begin
            accept = 1'b0;
        end
        // R3 carries the reserved index
        idxNext = (code == ACMD41) ? 6'h3F : frameIndex;
    end

    always_ff @(posedge sd_clk) begin
        if (reset) begin
            respStart <= 1'b0;
            cmdError  <= 1'b0;
            setRca    <= 1'b0;
            clearRca  <= 1'b0;
            setApp    <= 1'b0;
            clearApp  <= 1'b0;
        end else begin
            respStart <= frameValid && accept && respond;
            cmdError  <= frameValid && !accept;
            setRca    <= frameValid && accept && rcaSet;
            clearRca  <= frameValid && accept && rcaClear;
            setApp    <= frameValid && accept && appSet;
            clearApp  <= frameValid && !(accept && appSet);
        end
    end

    always_ff @(posedge sd_clk) begin
        if (frameValid) begin
            respKind   <= kindNext;
            respHeader <= {2'b00, idxNext, argNext};
        end
    end

endmodule

// File: rtl/sdCardState.sv
`timescale 1ns/1ps

module sdCardState (
    input  logic        sd_clk,
    input  logic        reset,
    input  logic        setRca,
    input  logic        clearRca,
    input  logic        setApp,
    input  logic        clearApp,
    output logic [15:0] rca,
    output logic        appCmd
);
    import sdCardPkg::*;

    // Relative card address published by CMD3 and dropped by CMD0
    always_ff @(posedge sd_clk) begin
        if (reset) begin
            rca <= '0;
        end else if (clearRca) begin
            rca <= '0;
        end else if (setRca) begin
            rca <= CARD_RCA;
        end
    end

    // CMD55 prefix valid for the next frame only
    always_ff @(posedge sd_clk) begin
        if (reset) begin
            appCmd <= 1'b0;
        end else if (setApp) begin
            appCmd <= 1'b1;
        end else if (clearApp) begin
            appCmd <= 1'b0;
        end
    end

    // The decoder issues at most one RCA action per frame
    assert property (@(posedge sd_clk) disable iff (reset) !(setRca && clearRca));

endmodule

// File: rtl/sdCmdReceiver.sv
`timescale 1ns/1ps

module sdCmdReceiver (
    input  logic                            sd_clk,
    input  logic                            reset,
    input  logic                            cmdIn,
    input  logic                            respBusy,
    output logic                            frameValid,
    output logic                            frameOk,
    output logic [sdCardPkg::IDX_WIDTH-1:0] frameIndex,
    output logic [sdCardPkg::ARG_WIDTH-1:0] frameArg
);
    import sdCardPkg::*;

    logic                      active;
    logic [5:0]                bitCount;
    logic [CMD_FRAME_BITS-2:0] shiftReg;
    logic [CMD_FRAME_BITS-1:0] frameBits;
    logic                      startBit;
    logic                      lastBit;
    logic                      crcClear;
    logic                      crcEnable;
    logic [CRC7_WIDTH-1:0]     crc;

    // Line idles high, a low sample starts a frame unless we are answering
    assign startBit = !active && !respBusy && !cmdIn;
    assign lastBit  = active && (bitCount == 6'(CMD_FRAME_BITS - 1));

    // Bit 0 of the frame ends up in the MSB
    assign frameBits = {shiftReg, cmdIn};

    // ======================================================================
    // Frame CRC, fed with bits 0 to 39
    // ======================================================================
    assign crcClear  = !active && !startBit;
    assign crcEnable = startBit || (active && (bitCount < 6'(HEADER_BITS)));

    sdCrc7 i_crc (
        .sd_clk  (sd_clk),
        .reset   (reset),
        .clear   (crcClear),
        .enable  (crcEnable),
        .dataBit (cmdIn),
        .crc     (crc)
    );

    // ======================================================================
    // Bit counter and frame assembly
    // ======================================================================
    always_ff @(posedge sd_clk) begin
        if (reset) begin
            active     <= 1'b0;
            bitCount   <= '0;
            frameValid <= 1'b0;
        end else begin
            frameValid <= lastBit;
            if (startBit) begin
                active   <= 1'b1;
                bitCount <= 6'd1;
            end else if (lastBit) begin
                active <= 1'b0;
            end else if (active) begin
                bitCount <= bitCount + 6'd1;
            end
        end
    end

    always_ff @(posedge sd_clk) begin
        if (startBit || active) begin
            shiftReg <= frameBits[CMD_FRAME_BITS-2:0];
        end
        if (lastBit) begin
            // Transmission bit, CRC field and end bit
            frameOk    <= frameBits[46] && (frameBits[7:1] == crc) && frameBits[0];
            frameIndex <= frameBits[45:40];
            frameArg   <= frameBits[39:8];
        end
    end

    // Frames are at least 48 cycles apart
    assert property (@(posedge sd_clk) disable iff (reset) frameValid |=> !frameValid);

endmodule

// File: rtl/sdCrc7.sv
`timescale 1ns/1ps

module sdCrc7 (
    input  logic                             sd_clk,
    input  logic                             reset,
    input  logic                             clear,
    input  logic                             enable,
    input  logic                             dataBit,
    output logic [sdCardPkg::CRC7_WIDTH-1:0] crc
);
    import sdCardPkg::*;

    logic feedback;

    // Polynomial x^7 + x^3 + 1
    assign feedback = dataBit ^ crc[CRC7_WIDTH-1];

    always_ff @(posedge sd_clk) begin
        if (reset || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

// File: rtl/sdCardPkg.sv
package sdCardPkg;

    // ======================================================================
    // Frame geometry
    // ======================================================================
    localparam int CMD_FRAME_BITS = 48;
    localparam int CRC7_WIDTH     = 7;
    localparam int ARG_WIDTH      = 32;
    localparam int IDX_WIDTH      = 6;

    // Start, transmission, index and argument bits covered by the CRC
    localparam int HEADER_BITS = CMD_FRAME_BITS - CRC7_WIDTH - 1;

    // Long response (CID)
    localparam int R2_BITS = 136;

    // Idle cycles between decoded command and first response bit
    localparam int RESP_GAP = 2;

    // ======================================================================
    // Command codes
    // ======================================================================
    // Upper bit is the application-command flag set by CMD55
    typedef enum logic [IDX_WIDTH:0] {
        CMD0   = {1'b0, 6'd0},
        CMD2   = {1'b0, 6'd2},
        CMD3   = {1'b0, 6'd3},
        CMD7   = {1'b0, 6'd7},
        CMD8   = {1'b0, 6'd8},
        CMD55  = {1'b0, 6'd55},
        ACMD6  = {1'b1, 6'd6},
        ACMD41 = {1'b1, 6'd41}
    } cmdCode_t;

    // R1 has a CRC over the header, R2 is the fixed CID, R3 has an all-ones CRC field
    typedef enum logic [1:0] {
        RESP_R1 = 2'd0,
        RESP_R2 = 2'd1,
        RESP_R3 = 2'd2
    } respKind_t;

    // ======================================================================
    // Fixed card values
    // ======================================================================
    localparam logic [15:0] CARD_RCA = 16'hAAAA;

    // Complete CMD2 response including its own CRC and end bit
    localparam logic [R2_BITS-1:0] CARD_CID =
        136'h3f0353445352313238808bb79d66014677;

    // Powered up, high capacity, full voltage window
    localparam logic [ARG_WIDTH-1:0] OCR_READY = 32'hC1FF8080;

    // Ready for data in the transfer state
    localparam logic [ARG_WIDTH-1:0] CARD_STATUS_R1 = 32'h00000900;

endpackage
